// ==== src/usbSiePkg.sv ====
package usbSiePkg;

    // ========================================
    // PID codes, low nibble as sent on the wire
    // ========================================
    localparam logic [3:0] PidOut   = 4'b0001;
    localparam logic [3:0] PidIn    = 4'b1001;
    localparam logic [3:0] PidSof   = 4'b0101;
    localparam logic [3:0] PidSetup = 4'b1101;
    localparam logic [3:0] PidData0 = 4'b0011;
    localparam logic [3:0] PidData1 = 4'b1011;
    localparam logic [3:0] PidAck   = 4'b0010;
    localparam logic [3:0] PidNak   = 4'b1010;
    localparam logic [3:0] PidStall = 4'b1110;

    // ========================================
    // Line timing and framing
    // ========================================
    localparam int unsigned BitCycles = 4;                      // clk48 cycles per 12 MHz bit
    localparam int unsigned PhaseBits = $clog2(BitCycles);
    localparam logic [PhaseBits-1:0] PhaseLast = PhaseBits'(BitCycles - 1);
    localparam logic [7:0]  SyncByte  = 8'h80;                  // KJKJKJKK
    localparam int unsigned StuffLimit = 6;                     // Ones before a forced zero
    localparam logic [15:0] ResetSe0Cycles = 16'd120;           // 2.5 us of SE0

    // CRC16 as used by DATA packets
    localparam logic [15:0] Crc16Poly     = 16'h8005;
    localparam logic [15:0] Crc16Residual = 16'h800D;           // Left after payload plus CRC

    // FSM state codes
    localparam logic [1:0] RxIdle = 2'd0;
    localparam logic [1:0] RxSync = 2'd1;
    localparam logic [1:0] RxData = 2'd2;
    localparam logic [1:0] RxEop  = 2'd3;

    localparam logic [2:0] TxIdle = 3'd0;
    localparam logic [2:0] TxSync = 3'd1;
    localparam logic [2:0] TxByte = 3'd2;
    localparam logic [2:0] TxCrc  = 3'd3;
    localparam logic [2:0] TxEop  = 3'd4;

    // PID byte, seen either whole or as code plus check nibble
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] pidCheck;   // Ones complement of pidCode
            logic [3:0] pidCode;    // Goes out first
        } f;
    } pidByteU;

endpackage

// ==== src/usbCrc16.sv ====
module usbCrc16 (
    input  logic        clk48,
    input  logic        reset,
    input  logic        clear,
    input  logic        enable,
    input  logic        dataBit,
    output logic [15:0] crc
);

    logic feedback;

    assign feedback = crc[15] ^ dataBit;    // Top bit against incoming bit

    // Serial LFSR, one bit per enable, LSB of each byte first
    always_ff @(posedge clk48) begin
        if (reset || clear) begin
            crc <= 16'hFFFF;                                    // Preset all ones
        end else if (enable) begin
            crc <= {crc[14:0], 1'b0} ^ (feedback ? usbSiePkg::Crc16Poly : 16'h0000);
        end
    end

endmodule

// ==== src/usbClockRecovery.sv ====
module usbClockRecovery (
    input  logic clk48,
    input  logic reset,
    input  logic hold,
    input  logic usbDp,
    input  logic usbDn,
    output logic lineP,
    output logic lineN,
    output logic bitStrobe
);

    logic [1:0] syncP;
    logic [1:0] syncN;
    logic       prevP;      // lineP one cycle back
    logic       edgeSeen;
    logic [usbSiePkg::PhaseBits-1:0] phase;

    assign lineP    = syncP[1];
    assign lineN    = syncN[1];
    assign edgeSeen = lineP != prevP;

    // Two-stage synchronizers, parked at J
    always_ff @(posedge clk48) begin
        if (reset) begin
            syncP <= 2'b11;
            syncN <= 2'b00;
            prevP <= 1'b1;
        end else begin
            syncP <= {syncP[0], usbDp};
            syncN <= {syncN[0], usbDn};
            prevP <= lineP;
        end
    end

    // Phase restarts on every edge so the strobe lands mid-bit
    always_ff @(posedge clk48) begin
        if (reset || hold) begin
            phase     <= '0;
            bitStrobe <= 1'b0;                                  // Quiet while we drive the line
        end else begin
            if (edgeSeen || phase == usbSiePkg::PhaseLast) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
            bitStrobe <= (phase == '0) && !edgeSeen;             // Two cycles after an edge
        end
    end

    // A strobe is one cycle wide even when an edge lands right after it
    assert property (@(posedge clk48) disable iff (reset) bitStrobe |=> !bitStrobe);

endmodule

// ==== src/usbRx.sv ====
module usbRx (
    input  logic       clk48,
    input  logic       reset,
    input  logic       lineActive,
    input  logic       lineP,
    input  logic       lineN,
    input  logic       bitStrobe,
    output logic       usbResetDetect,
    output logic [7:0] rxData,
    output logic       rxDataValid,
    output logic       rxIsLastByte,
    output logic       rxKeepPacket,
    input  logic       rxReady
);

    logic [1:0]  state;
    logic        lastP;         // Level at the previous strobe
    logic [2:0]  zeroCnt;
    logic [2:0]  onesCnt;
    logic [2:0]  bitCnt;
    logic [7:0]  shiftReg;
    logic [7:0]  heldByte;      // Held back until we know whether it is last
    logic        heldValid;
    logic        gotPid;
    logic        badStuff;
    logic        overrun;
    logic [15:0] se0Cnt;
    logic [15:0] crc;
    usbSiePkg::pidByteU rxPid;

    logic       se0;
    logic       rxBit;
    logic       takeBit;
    logic       byteDone;
    logic       eopNow;
    logic       pushByte;
    logic       isData;
    logic       verdict;
    logic [7:0] newByte;

    assign se0      = !lineP && !lineN;
    assign rxBit    = lineP == lastP;                           // No transition decodes as one
    assign newByte  = {rxBit, shiftReg[7:1]};                   // LSB arrives first
    assign takeBit  = bitStrobe && state == usbSiePkg::RxData && !se0
                      && onesCnt != 3'(usbSiePkg::StuffLimit);
    assign byteDone = takeBit && bitCnt == 3'd7;
    assign eopNow   = bitStrobe && state == usbSiePkg::RxData && se0;
    assign pushByte = heldValid && (byteDone || eopNow);

    // Packet verdict, only sampled with the last byte
    assign isData  = rxPid.f.pidCode == usbSiePkg::PidData0
                     || rxPid.f.pidCode == usbSiePkg::PidData1;
    assign verdict = rxPid.f.pidCheck == ~rxPid.f.pidCode
                     && (!isData || crc == usbSiePkg::Crc16Residual)
                     && !badStuff && !overrun && bitCnt == 3'd0
                     && !(rxDataValid && !rxReady);             // Last byte would overwrite too

    usbCrc16 crc_i (
        .clk48  (clk48),
        .reset  (reset),
        .clear  (state != usbSiePkg::RxData),
        .enable (takeBit && gotPid),                            // Payload and CRC, no PID
        .dataBit(rxBit),
        .crc    (crc)
    );

    // ========================================
    // Packet FSM
    // ========================================
    always_ff @(posedge clk48) begin
        if (reset || lineActive) begin
            state     <= usbSiePkg::RxIdle;
            lastP     <= 1'b1;                                  // J
            zeroCnt   <= '0;
            onesCnt   <= '0;
            bitCnt    <= '0;
            heldValid <= 1'b0;
            gotPid    <= 1'b0;
            badStuff  <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            if (pushByte && rxDataValid && !rxReady) begin
                overrun <= 1'b1;                                // Backend too slow
            end
            case (state)
                usbSiePkg::RxIdle: begin
                    if (bitStrobe && !lineP && lineN) begin     // First K of SYNC
                        state     <= usbSiePkg::RxSync;
                        lastP     <= 1'b0;
                        zeroCnt   <= 3'd1;
                        heldValid <= 1'b0;
                        gotPid    <= 1'b0;
                        badStuff  <= 1'b0;
                        overrun   <= 1'b0;
                    end
                end
                usbSiePkg::RxSync: begin
                    if (bitStrobe) begin
                        lastP <= lineP;
                        if (se0) begin
                            state <= usbSiePkg::RxEop;
                        end else if (!rxBit) begin
                            zeroCnt <= zeroCnt + 3'(zeroCnt != 3'd7);
                        end else if (zeroCnt >= 3'd5) begin    // Closing one of SYNC
                            state   <= usbSiePkg::RxData;
                            onesCnt <= 3'd1;
                            bitCnt  <= '0;
                        end else begin
                            state <= usbSiePkg::RxIdle;         // Noise
                        end
                    end
                end
                usbSiePkg::RxData: begin
                    if (bitStrobe) begin
                        lastP <= lineP;
                        if (se0) begin
                            state     <= usbSiePkg::RxEop;
                            heldValid <= 1'b0;                  // Pushed as last byte
                        end else if (onesCnt == 3'(usbSiePkg::StuffLimit)) begin
                            onesCnt <= '0;                      // Drop stuffed zero
                            if (rxBit) begin
                                badStuff <= 1'b1;               // Seventh one kills packet
                            end
                        end else begin
                            shiftReg <= newByte;
                            bitCnt   <= bitCnt + 1'b1;
                            onesCnt  <= rxBit ? onesCnt + 1'b1 : 3'd0;
                            if (byteDone) begin
                                heldByte  <= newByte;
                                heldValid <= 1'b1;
                                gotPid    <= 1'b1;
                                if (!gotPid) begin
                                    rxPid.raw <= newByte;
                                end
                            end
                        end
                    end
                end
                default: begin
                    if (!se0) begin                             // SE0 over, back at J
                        state <= usbSiePkg::RxIdle;
                        lastP <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Backend register, overwritten when not taken in time
    always_ff @(posedge clk48) begin
        if (reset) begin
            rxDataValid  <= 1'b0;
            rxIsLastByte <= 1'b0;
            rxKeepPacket <= 1'b0;
        end else if (pushByte) begin
            rxData       <= heldByte;
            rxDataValid  <= 1'b1;
            rxIsLastByte <= eopNow;
            rxKeepPacket <= eopNow && verdict;
        end else if (rxReady) begin
            rxDataValid <= 1'b0;
        end
    end

    // Bus reset is a long SE0
    always_ff @(posedge clk48) begin
        if (reset || lineActive || !se0) begin
            se0Cnt         <= '0;
            usbResetDetect <= 1'b0;
        end else if (se0Cnt == usbSiePkg::ResetSe0Cycles) begin
            usbResetDetect <= 1'b1;
        end else begin
            se0Cnt <= se0Cnt + 1'b1;
        end
    end

    // Offered byte holds until taken, unless the line forces a new one in
    assert property (@(posedge clk48) disable iff (reset)
        rxDataValid && !rxReady && !pushByte |=> rxDataValid && $stable(rxData));

endmodule

// ==== src/usbTx.sv ====
module usbTx (
    input  logic       clk48,
    input  logic       reset,
    input  logic [7:0] txData,
    input  logic       txDataValid,
    input  logic       txIsLastByte,
    output logic       txReady,
    output logic       txSending,
    output logic       outEn,
    output logic       usbDpOut,
    output logic       usbDnOut
);

    logic [2:0]  phase;
    logic [usbSiePkg::PhaseBits-1:0] timer;
    logic [2:0]  bitIdx;
    logic [7:0]  shiftReg;
    logic        curLast;       // Byte in shiftReg ends the packet
    logic        pidPhase;      // PID byte on the wire, kept out of the CRC
    logic        crcHi;
    logic [1:0]  eopCnt;
    logic [2:0]  onesCnt;
    logic        lineLvl;       // One is J
    logic [15:0] crc;
    logic [15:0] crcSend;
    usbSiePkg::pidByteU txPid;

    logic tick;
    logic stuffNow;
    logic curBit;
    logic nextLvl;
    logic isData;

    assign tick     = timer == usbSiePkg::PhaseLast;
    assign stuffNow = onesCnt == 3'(usbSiePkg::StuffLimit);
    assign crcSend  = {<<{~crc}};                               // Complemented, low byte first
    assign curBit   = (phase == usbSiePkg::TxCrc) ? crcSend[{crcHi, bitIdx}] : shiftReg[0];
    assign nextLvl  = (stuffNow || !curBit) ? !lineLvl : lineLvl;   // NRZI
    assign isData   = txPid.f.pidCode == usbSiePkg::PidData0
                      || txPid.f.pidCode == usbSiePkg::PidData1;
    assign txSending = outEn;

    // Idle, or the slot where the next byte is due
    assign txReady = (phase == usbSiePkg::TxIdle)
                     || (phase == usbSiePkg::TxByte && tick && !stuffNow
                         && bitIdx == 3'd7 && !curLast);

    usbCrc16 crc_i (
        .clk48  (clk48),
        .reset  (reset),
        .clear  (phase == usbSiePkg::TxIdle),
        .enable (phase == usbSiePkg::TxByte && tick && !stuffNow && !pidPhase),
        .dataBit(shiftReg[0]),
        .crc    (crc)
    );

    // ========================================
    // Bit sequencer
    // ========================================
    always_ff @(posedge clk48) begin
        if (reset) begin
            phase    <= usbSiePkg::TxIdle;
            timer    <= '0;
            bitIdx   <= '0;
            onesCnt  <= '0;
            eopCnt   <= '0;
            crcHi    <= 1'b0;
            pidPhase <= 1'b0;
            curLast  <= 1'b0;
            lineLvl  <= 1'b1;
            outEn    <= 1'b0;
            usbDpOut <= 1'b1;                                   // J
            usbDnOut <= 1'b0;
        end else begin
            timer <= tick ? '0 : timer + 1'b1;
            case (phase)
                usbSiePkg::TxIdle: begin
                    timer <= usbSiePkg::PhaseLast;              // First bit on next cycle
                    if (txDataValid) begin
                        txPid.raw <= txData;                    // PID waits behind SYNC
                        curLast   <= txIsLastByte;
                        shiftReg  <= usbSiePkg::SyncByte;
                        bitIdx    <= '0;
                        onesCnt   <= '0;
                        eopCnt    <= '0;
                        lineLvl   <= 1'b1;
                        phase     <= usbSiePkg::TxSync;
                    end
                end
                usbSiePkg::TxEop: begin
                    if (tick && stuffNow) begin                 // Trailing stuffed zero
                        lineLvl  <= nextLvl;
                        usbDpOut <= nextLvl;
                        usbDnOut <= !nextLvl;
                        onesCnt  <= '0;
                    end else if (tick) begin
                        eopCnt <= eopCnt + 1'b1;
                        if (eopCnt == 2'd3) begin
                            outEn <= 1'b0;                      // J bit time done
                            phase <= usbSiePkg::TxIdle;
                        end else begin
                            usbDpOut <= eopCnt == 2'd2;         // SE0, SE0, then J
                            usbDnOut <= 1'b0;
                            lineLvl  <= 1'b1;
                        end
                    end
                end
                default: begin                                  // SYNC, bytes and CRC
                    if (tick) begin
                        outEn    <= 1'b1;
                        lineLvl  <= nextLvl;
                        usbDpOut <= nextLvl;
                        usbDnOut <= !nextLvl;
                        onesCnt  <= (stuffNow || !curBit) ? 3'd0 : onesCnt + 1'b1;
                        if (!stuffNow) begin
                            shiftReg <= shiftReg >> 1;
                            bitIdx   <= bitIdx + 1'b1;
                            if (bitIdx == 3'd7) begin
                                pidPhase <= 1'b0;
                                case (phase)
                                    usbSiePkg::TxSync: begin
                                        shiftReg <= txPid.raw;
                                        pidPhase <= 1'b1;
                                        phase    <= usbSiePkg::TxByte;
                                    end
                                    usbSiePkg::TxByte: begin
                                        crcHi <= 1'b0;
                                        if (curLast) begin
                                            phase <= isData ? usbSiePkg::TxCrc : usbSiePkg::TxEop;
                                        end else if (txDataValid) begin
                                            shiftReg <= txData;
                                            curLast  <= txIsLastByte;
                                        end else begin
                                            phase <= usbSiePkg::TxEop;  // Underrun, no CRC
                                        end
                                    end
                                    default: begin
                                        crcHi <= 1'b1;
                                        if (crcHi) begin
                                            phase <= usbSiePkg::TxEop;
                                        end
                                    end
                                endcase
                            end
                        end
                    end
                end
            endcase
        end
    end

    // SE0 only ever leaves this engine as part of EOP
    assert property (@(posedge clk48) disable iff (reset)
        !usbDpOut && !usbDnOut |-> phase == usbSiePkg::TxEop);

endmodule

// ==== src/usbSie.sv ====
module usbSie (
    input  logic       clk48,
    input  logic       reset,
    input  logic       usbDp,
    input  logic       usbDn,
    output logic       usbDpOut,
    output logic       usbDnOut,
    output logic       usbOutEn,
    output logic       usbResetDetect,
    output logic [7:0] rxData,
    output logic       rxDataValid,
    output logic       rxIsLastByte,
    output logic       rxKeepPacket,
    input  logic       rxReady,
    input  logic [7:0] txData,
    input  logic       txDataValid,
    input  logic       txIsLastByte,
    output logic       txReady,
    output logic       txSending
);

    logic lineP;
    logic lineN;
    logic bitStrobe;
    logic outEn;        // High while we own the line

    assign usbOutEn = outEn;

    // Bit timing, restarted whenever the transmitter lets go of the line
    usbClockRecovery clockRecovery_i (
        .clk48    (clk48),
        .reset    (reset),
        .hold     (outEn),
        .usbDp    (usbDp),
        .usbDn    (usbDn),
        .lineP    (lineP),
        .lineN    (lineN),
        .bitStrobe(bitStrobe)
    );

    // ========================================
    // Receive path
    // ========================================
    usbRx rx_i (
        .clk48         (clk48),
        .reset         (reset),
        .lineActive    (outEn),                                 // Deaf to our own packets
        .lineP         (lineP),
        .lineN         (lineN),
        .bitStrobe     (bitStrobe),
        .usbResetDetect(usbResetDetect),
        .rxData        (rxData),
        .rxDataValid   (rxDataValid),
        .rxIsLastByte  (rxIsLastByte),
        .rxKeepPacket  (rxKeepPacket),
        .rxReady       (rxReady)
    );

    // ========================================
    // Transmit path
    // ========================================
    usbTx tx_i (
        .clk48       (clk48),
        .reset       (reset),
        .txData      (txData),
        .txDataValid (txDataValid),
        .txIsLastByte(txIsLastByte),
        .txReady     (txReady),
        .txSending   (txSending),
        .outEn       (outEn),
        .usbDpOut    (usbDpOut),
        .usbDnOut    (usbDnOut)
    );

endmodule

// ==== dv/usbHostModel.sv ====
module usbHostModel (
    input  logic clk48,
    output logic usbDp,
    output logic usbDn,
    input  logic usbDpOut,
    input  logic usbDnOut,
    input  logic usbOutEn
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        usbDp = 1'b1;                                           // Idle J
        usbDn = 1'b0;
    end

    // One bit time of a given line state
    task automatic driveLine(input logic dp, input logic dn);
        @(posedge clk48);
        usbDp <= dp;
        usbDn <= dn;
        repeat (usbSiePkg::BitCycles - 1) @(posedge clk48);
    endtask

    // SYNC, bytes LSB first, stuffing, NRZI from J, then EOP
    task automatic sendPacket(input logic [7:0] bytes [0:9], input int len);
        logic [7:0] sync;
        logic       lvl;
        logic       bitVal;
        int         ones;
        sync = usbSiePkg::SyncByte;
        lvl  = 1'b1;
        ones = 0;
        for (int b = 0; b < (len + 1) * 8; b++) begin
            bitVal = (b < 8) ? sync[b] : bytes[b / 8 - 1][b % 8];
            if (!bitVal) lvl = !lvl;                            // Zero toggles
            driveLine(lvl, !lvl);
            ones = bitVal ? ones + 1 : 0;
            if (ones == usbSiePkg::StuffLimit) begin
                lvl  = !lvl;                                    // Stuffed zero
                driveLine(lvl, !lvl);
                ones = 0;
            end
        end
        driveLine(1'b0, 1'b0);
        driveLine(1'b0, 1'b0);
        driveLine(1'b1, 1'b0);                                  // Back to J
    endtask

    task automatic sendSe0(input int cycles);
        @(posedge clk48);
        usbDp <= 1'b0;
        usbDn <= 1'b0;
        repeat (cycles) @(posedge clk48);
        usbDp <= 1'b1;
    endtask

    // Decode device output into bytes, SYNC stripped
    task automatic capturePacket(output logic [7:0] bytes [0:9], output int len);
        logic       prev;
        logic       bitVal;
        logic [7:0] sr;
        int         ones;
        int         nbits;
        prev  = 1'b1;
        sr    = 8'h00;
        ones  = 0;
        nbits = 0;
        len   = 0;
        while (!usbOutEn) @(posedge clk48);
        @(posedge clk48);                                       // Move towards mid-bit
        while (usbDpOut || usbDnOut) begin
            if (ones == usbSiePkg::StuffLimit) begin
                ones = 0;                                       // Drop stuffed bit
            end else begin
                bitVal = usbDpOut == prev;
                ones   = bitVal ? ones + 1 : 0;
                sr     = {bitVal, sr[7:1]};
                nbits++;
                if (nbits % 8 == 0 && nbits > 8 && len < 10) begin
                    bytes[len] = sr;
                    len++;
                end
            end
            prev = usbDpOut;
            repeat (usbSiePkg::BitCycles) @(posedge clk48);
        end
        while (usbOutEn) @(posedge clk48);
    endtask

endmodule

// ==== dv/tbUsbSie.sv ====
module tbUsbSie;

    timeunit 1ns;
    timeprecision 100ps;

    logic       clk48 = 1'b0;
    logic       reset;
    logic       usbDp;
    logic       usbDn;
    logic       usbDpOut;
    logic       usbDnOut;
    logic       usbOutEn;
    logic       usbResetDetect;
    logic [7:0] rxData;
    logic       rxDataValid;
    logic       rxIsLastByte;
    logic       rxKeepPacket;
    logic       rxReady;
    logic [7:0] txData;
    logic       txDataValid;
    logic       txIsLastByte;
    logic       txReady;
    logic       txSending;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycleLimit = 0;
    int seed = 32'h581a;

    // ========================================
    // Stimulus table
    // ========================================
    // dir 1 is device transmit; corrupt 1 flips a payload bit, 2 breaks the PID
    // stall 1 is random rxReady gaps, 2 holds rxReady low over the packet
    localparam int NumTests = 9;
    logic        dirTab     [0:NumTests-1] = '{0, 0, 0, 0, 0, 0, 0, 1, 1};
    logic [3:0]  pidTab     [0:NumTests-1] = '{4'b0011, 4'b1011, 4'b0011, 4'b1011,
        4'b0010, 4'b0011, 4'b1011, 4'b1011, 4'b0010};
    int          lenTab     [0:NumTests-1] = '{5, 4, 3, 1, 0, 6, 3, 4, 0};
    logic [47:0] payTab     [0:NumTests-1] = '{48'h0201FFFFFF, 48'h007EFFFF, 48'h563412,
        48'hAA, 48'h0, 48'h0FC3FF55FF00 >> 0, 48'h030201, 48'h01EEFFC0, 48'h0};
    logic [1:0]  corruptTab [0:NumTests-1] = '{0, 0, 1, 2, 0, 0, 0, 0, 0};
    logic [1:0]  stallTab   [0:NumTests-1] = '{0, 0, 0, 0, 0, 1, 2, 0, 0};
    logic        keepTab    [0:NumTests-1] = '{1, 1, 0, 0, 1, 1, 0, 1, 1};

    always #4 clk48 = ~clk48;                                   // 8 ns period

    usbSie dut_i (.*);

    usbHostModel hostModel_i (
        .clk48   (clk48),
        .usbDp   (usbDp),
        .usbDn   (usbDn),
        .usbDpOut(usbDpOut),
        .usbDnOut(usbDnOut),
        .usbOutEn(usbOutEn)
    );

    // Watchdog
    always @(posedge clk48) begin
        cycles++;
        if (cycleLimit != 0 && cycles > cycleLimit) begin
            $display("Timeout: run exceeded %0d cycles", cycleLimit);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    // USB CRC16 over bytes 1..n-1, returned as the two wire bytes {hi, lo}
    function automatic logic [15:0] refCrc(input logic [7:0] d [0:9], input int n);
        logic [15:0] c;
        logic [15:0] r;
        logic        fb;
        c = 16'hFFFF;
        for (int i = 1; i < n; i++) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[15] ^ d[i][b];
                c  = {c[14:0], 1'b0} ^ (fb ? usbSiePkg::Crc16Poly : 16'h0000);
            end
        end
        for (int b = 0; b < 16; b++) r[b] = ~c[15 - b];          // Inverted, reflected
        return r;
    endfunction

    task automatic takeByte();
        do @(posedge clk48); while (!(rxDataValid && rxReady));
    endtask

    // Collect one packet from the backend side
    task automatic receiveBytes(input logic [7:0] exp [0:9], input int n, input logic stall,
                                input logic keepExp);
        int span;
        for (int k = 0; k < n; k++) begin
            takeByte();
            checkValue("rxData", 16'(rxData), 16'(exp[k]));
            checkValue("rxIsLastByte", 16'(rxIsLastByte), 16'(k == n - 1));
            if (k == n - 1) checkValue("rxKeepPacket", 16'(rxKeepPacket), 16'(keepExp));
            if (stall && k % 2 == 0 && k < n - 3) begin
                // Hold rxReady low while the next byte comes out
                span = usbSiePkg::BitCycles * 4 + ($random(seed) & 7);  // Under 8 bit times
                repeat (usbSiePkg::BitCycles * 5) @(posedge clk48);
                rxReady <= 1'b0;
                repeat (span) @(posedge clk48);
                rxReady <= 1'b1;
            end
        end
    endtask

    // Feed bytes to the transmitter over valid/ready
    task automatic driveTx(input logic [7:0] pkt [0:9], input int n);
        int k;
        k = 0;
        @(posedge clk48);
        txData       <= pkt[0];
        txDataValid  <= 1'b1;
        txIsLastByte <= n == 1;
        while (k < n) begin
            @(posedge clk48);
            if (txDataValid && txReady) begin
                k++;
                if (k < n) begin
                    txData       <= pkt[k];
                    txIsLastByte <= k == n - 1;
                end else begin
                    txDataValid <= 1'b0;
                end
            end
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        logic [7:0]  pkt [0:9];
        logic [7:0]  cap [0:9];
        logic [15:0] crcWire;
        int          n;
        int          capLen;
        int          totalBits;
        reset        = 1'b1;
        rxReady      = 1'b1;
        txData       = 8'h00;
        txDataValid  = 1'b0;
        txIsLastByte = 1'b0;
        totalBits    = 0;
        for (int t = 0; t < NumTests; t++) totalBits += (lenTab[t] + 5) * 8;
        cycleLimit = totalBits * usbSiePkg::BitCycles * 2 + 2000;

        repeat (8) @(posedge clk48);
        reset <= 1'b0;
        repeat (2) @(posedge clk48);
        checkValue("usbOutEn", 16'(usbOutEn), 16'h0);
        checkValue("rxDataValid", 16'(rxDataValid), 16'h0);
        checkValue("usbResetDetect", 16'(usbResetDetect), 16'h0);
        checkValue("txSending", 16'(txSending), 16'h0);
        checkValue("txReady", 16'(txReady), 16'h1);

        for (int t = 0; t < NumTests; t++) begin
            pkt[0] = (corruptTab[t] == 2) ? {4'h0, pidTab[t]} : {~pidTab[t], pidTab[t]};
            for (int k = 0; k < lenTab[t]; k++) pkt[k + 1] = payTab[t][8 * k +: 8];
            n = lenTab[t] + 1;
            if (pidTab[t] == usbSiePkg::PidData0 || pidTab[t] == usbSiePkg::PidData1) begin
                crcWire    = refCrc(pkt, n);
                pkt[n]     = crcWire[7:0];                      // Low byte first
                pkt[n + 1] = crcWire[15:8];
                n += 2;
            end
            if (corruptTab[t] == 1) pkt[1][3] = ~pkt[1][3];
            repeat (10) @(posedge clk48);
            if (dirTab[t]) begin
                fork
                    driveTx(pkt, n - ((pidTab[t] == usbSiePkg::PidAck) ? 0 : 2));
                    hostModel_i.capturePacket(cap, capLen);
                join
                checkValue("capturedLength", 16'(capLen), 16'(n));
                for (int k = 0; k < n && k < capLen; k++) begin
                    checkValue("capturedByte", 16'(cap[k]), 16'(pkt[k]));
                end
                checkValue("usbOutEn", 16'(usbOutEn), 16'h0);
            end else if (stallTab[t] == 2) begin
                rxReady <= 1'b0;                                // Backend asleep all packet
                hostModel_i.sendPacket(pkt, n);
                repeat (4) @(posedge clk48);
                rxReady <= 1'b1;
                takeByte();
                checkValue("rxIsLastByte", 16'(rxIsLastByte), 16'h1);
                checkValue("rxKeepPacket", 16'(rxKeepPacket), 16'(keepTab[t]));
            end else begin
                fork
                    hostModel_i.sendPacket(pkt, n);
                    receiveBytes(pkt, n, stallTab[t] == 1, keepTab[t]);
                join
            end
        end

        // Bus reset
        hostModel_i.sendSe0(usbSiePkg::ResetSe0Cycles + 10);
        checkValue("usbResetDetect", 16'(usbResetDetect), 16'h1);
        repeat (6) @(posedge clk48);
        checkValue("usbResetDetect", 16'(usbResetDetect), 16'h0);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
src/usbSiePkg.sv
src/usbCrc16.sv
src/usbClockRecovery.sv
src/usbRx.sv
src/usbTx.sv
src/usbSie.sv
dv/usbHostModel.sv
dv/tbUsbSie.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the USB SIE testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbUsbSie -f vlog.f -o simUsbSie
./obj_dir/simUsbSie | tee sim.log

if grep -q "All checks passed" sim.log; then
    exit 0
fi
exit 1
